/* design/booth_defs.svh */
// width macros for the radix-4 Booth fixed-width multiplier
// and the counts that follow from the operand width
`ifndef BOOTH_DEFS_SVH
`define BOOTH_DEFS_SVH

// operand and result width, must be even
`define MUL_WIDTH 24

// one radix-4 digit per pair of multiplier bits
`define BOOTH_DIGITS (`MUL_WIDTH / 2)

// lowest full-product column that survives truncation
`define KEEP_LSB (`MUL_WIDTH - 2)

// a kept row spans columns KEEP_LSB up to 2N-1
`define ROW_WIDTH (`MUL_WIDTH + 2)

// wide enough to count every digit as nonzero
`define COMP_WIDTH $clog2(`BOOTH_DIGITS + 1)

`endif

/* design/booth_pkg.sv */
// operand, partial-product row, carry-save pair and stage payload types
// shared by all stages of the Booth multiplier pipeline
`include "booth_defs.svh"

package booth_pkg;

  // one signed operand, the product uses the same fixed-point format
  typedef logic signed [`MUL_WIDTH-1:0] mul_operand_t;

  // both operands of one multiply travel together on the input stream
  typedef struct packed {
    mul_operand_t x;
    mul_operand_t y;
  } mul_in_t;

  // a partial-product row cut down to columns KEEP_LSB .. 2N-1
  // bit 0 of the row sits at column KEEP_LSB
  typedef logic [`ROW_WIDTH-1:0] pp_row_t;

  // half the nonzero digit count, added in as truncation compensation
  typedef logic [`COMP_WIDTH-1:0] comp_cnt_t;

  // payload of the encoder stage
  // row i belongs to digit i, comp enters at the lowest kept column
  typedef struct packed {
    pp_row_t [`BOOTH_DIGITS-1:0] rows;
    comp_cnt_t                   comp;
  } pp_rows_t;

  // redundant result of the carry-save tree
  // the carry vector is already aligned, so the value is sum + carry
  typedef struct packed {
    pp_row_t sum;
    pp_row_t carry;
  } csa_pair_t;

endpackage

/* design/booth_encoder.sv */
// first pipeline stage with radix-4 Booth recoding, exact row negation,
// column truncation and the compensation count
`include "booth_defs.svh"

module booth_encoder
  import booth_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     advance,
  input  logic     in_valid,
  input  mul_in_t  in_data,
  output logic     enc_valid,
  output pp_rows_t enc_rows
);

  // multiplicand sign-extended to the full 2N-bit product width
  logic [2*`MUL_WIDTH-1:0] x_ext;
  // multiplier with the implicit y[-1] = 0 appended below bit 0
  logic [`MUL_WIDTH:0]     y_pad;
  // scratch values reused by every digit of the loop below
  logic [2:0]              win;
  logic [2*`MUL_WIDTH-1:0] mag;
  logic [2*`MUL_WIDTH-1:0] full;
  logic                    neg;
  // one spare bit so that the round-up below cannot overflow
  logic [`COMP_WIDTH:0]    nz_cnt;
  pp_rows_t                rows_d;

  always_comb begin
    x_ext  = {{`MUL_WIDTH{in_data.x[`MUL_WIDTH-1]}}, in_data.x};
    y_pad  = {in_data.y, 1'b0};
    nz_cnt = '0;
    win    = '0;
    mag    = '0;
    full   = '0;
    neg    = 1'b0;
    for (int i = 0; i < `BOOTH_DIGITS; i++) begin
      // window {y[2i+1], y[2i], y[2i-1]} gives digit -2*y[2i+1] + y[2i] + y[2i-1]
      win = y_pad[2*i +: 3];
      case (win)
        3'b001, 3'b010: begin
          mag = x_ext;
          neg = 1'b0;
        end
        3'b011: begin
          mag = x_ext << 1;
          neg = 1'b0;
        end
        3'b100: begin
          mag = x_ext << 1;
          neg = 1'b1;
        end
        3'b101, 3'b110: begin
          mag = x_ext;
          neg = 1'b1;
        end
        default: begin
          // 000 and 111 both recode to a zero digit
          mag = '0;
          neg = 1'b0;
        end
      endcase
      // the negation is exact in 2N bits, no +1 is pushed into the dropped columns
      full = neg ? -mag : mag;
      // each digit weighs 4^i, that is two columns per digit
      full = full << (2*i);
      // keep only columns 2N-1 down to KEEP_LSB
      rows_d.rows[i] = full[2*`MUL_WIDTH-1 -: `ROW_WIDTH];
      if (win != 3'b000 && win != 3'b111) begin
        nz_cnt = nz_cnt + (`COMP_WIDTH+1)'(1);
      end
    end
    // compensation is ceil(nonzero digits / 2)
    rows_d.comp = comp_cnt_t'((nz_cnt + (`COMP_WIDTH+1)'(1)) >> 1);
  end

  // valid follows the shared advance strobe, so a stall freezes the whole pipe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enc_valid <= 1'b0;
    end else if (advance) begin
      enc_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      enc_rows <= rows_d;
    end
  end

  // the valid bit must come out of reset clean and stay known for the rest of the run
  a_enc_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(enc_valid)
  );

endmodule

/* design/pp_compress.sv */
// second pipeline stage that reduces the truncated rows and the
// compensation term to one sum/carry pair with a chain of 3:2 counters
`include "booth_defs.svh"

module pp_compress
  import booth_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      advance,
  input  logic      enc_valid,
  input  pp_rows_t  enc_rows,
  output logic      csa_valid,
  output csa_pair_t csa_out
);

  // running sum and carry after each counter level
  // level 0 is just the first two rows
  pp_row_t lvl_s [`BOOTH_DIGITS];
  pp_row_t lvl_c [`BOOTH_DIGITS];
  // third input of each level, rows 2 .. D-1 and then the comp vector
  pp_row_t addend [`BOOTH_DIGITS-1];
  pp_row_t comp_vec;

  // comp lands on the lowest kept column, which is bit 0 of a row
  assign comp_vec = pp_row_t'(enc_rows.comp);

  assign lvl_s[0] = enc_rows.rows[0];
  assign lvl_c[0] = enc_rows.rows[1];

  for (genvar k = 0; k < `BOOTH_DIGITS-1; k++) begin : g_addend
    if (k < `BOOTH_DIGITS-2) begin : g_row
      assign addend[k] = enc_rows.rows[k+2];
    end else begin : g_comp
      assign addend[k] = comp_vec;
    end
  end

  // ripple of full-adder columns, one level per extra input vector
  // the carry moves one column up and anything above 2N-1 is dropped
  for (genvar k = 0; k < `BOOTH_DIGITS-1; k++) begin : g_lvl
    pp_row_t maj;
    assign maj = (lvl_s[k] & lvl_c[k]) | (lvl_s[k] & addend[k]) |
                 (lvl_c[k] & addend[k]);
    assign lvl_s[k+1] = lvl_s[k] ^ lvl_c[k] ^ addend[k];
    assign lvl_c[k+1] = {maj[`ROW_WIDTH-2:0], 1'b0};
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      csa_valid <= 1'b0;
    end else if (advance) begin
      csa_valid <= enc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      csa_out.sum   <= lvl_s[`BOOTH_DIGITS-1];
      csa_out.carry <= lvl_c[`BOOTH_DIGITS-1];
    end
  end

  // reference total of one encoder payload, modulo 2^ROW_WIDTH
  function automatic pp_row_t row_total(pp_rows_t r);
    pp_row_t acc;
    acc = pp_row_t'(r.comp);
    for (int i = 0; i < `BOOTH_DIGITS; i++) begin
      acc = acc + r.rows[i];
    end
    return acc;
  endfunction

  // the registered pair must carry the same value as the rows it was built from
  a_csa_preserves_sum: assert property (
    @(posedge clk) disable iff (!rst_n)
    ($past(advance) && $past(enc_valid)) |->
      (pp_row_t'(csa_out.sum + csa_out.carry) == $past(row_total(enc_rows)))
  );

endmodule

/* design/final_adder.sv */
// third pipeline stage with the carry-propagate add, product bit
// selection and the single back-pressure condition of the pipeline
`include "booth_defs.svh"

module final_adder
  import booth_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         csa_valid,
  input  csa_pair_t    csa_out,
  input  logic         out_ready,
  output logic         advance,
  output logic         out_valid,
  output mul_operand_t out_data
);

  // bit 0 of the total is column N-2 of the full product
  pp_row_t total;

  assign total = csa_out.sum + csa_out.carry;

  // the whole pipe moves unless a result is waiting on the output
  // bubbles are not squeezed out, every stage shares this one strobe
  assign advance = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (advance) begin
      out_valid <= csa_valid;
    end
  end

  // product columns N-1 .. 2N-2 sit at bits 1 .. N of the total
  always_ff @(posedge clk) begin
    if (advance) begin
      out_data <= total[`MUL_WIDTH:1];
    end
  end

  // a stalled result and the carry-save pair behind it must both hold
  // until the consumer takes the result
  a_out_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=>
      ($stable(out_valid) && $stable(out_data) && $stable(csa_valid) && $stable(csa_out))
  );

endmodule

/* design/booth_mul_top.sv */
// top level of the pipelined Booth multiplier
// connects encoder, compressor and final adder in a line
`include "booth_defs.svh"

module booth_mul_top
  import booth_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         in_valid,
  input  mul_in_t      in_data,
  input  logic         out_ready,
  output logic         in_ready,
  output logic         out_valid,
  output mul_operand_t out_data
);

  // shared stall strobe, generated next to the output register
  logic      advance;
  logic      enc_valid;
  pp_rows_t  enc_rows;
  logic      csa_valid;
  csa_pair_t csa_out;

  // a new operand pair is taken whenever the pipe moves
  assign in_ready = advance;

  booth_encoder u_booth_encoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance   (advance),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .enc_valid (enc_valid),
    .enc_rows  (enc_rows)
  );

  pp_compress u_pp_compress (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance   (advance),
    .enc_valid (enc_valid),
    .enc_rows  (enc_rows),
    .csa_valid (csa_valid),
    .csa_out   (csa_out)
  );

  final_adder u_final_adder (
    .clk       (clk),
    .rst_n     (rst_n),
    .csa_valid (csa_valid),
    .csa_out   (csa_out),
    .out_ready (out_ready),
    .advance   (advance),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

/* testbench/booth_checker.sv */
// stream monitor with the reference product, the queue of expected results
// and the latency, stall and reset checks
`include "booth_defs.svh"

module booth_checker
  import booth_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         in_valid,
  input  logic         in_ready,
  input  mul_in_t      in_data,
  input  logic         out_valid,
  input  logic         out_ready,
  input  mul_operand_t out_data,
  output int           value_errs,
  output int           proto_errs,
  output int           compared,
  output int           pending
);

  // one accepted input with its expected product, entry cycle and stall count
  typedef struct packed {
    mul_in_t      ops;
    mul_operand_t want;
    longint       cyc;
    longint       stl;
  } pend_t;

  pend_t        fifo [$];
  longint       cycle;
  longint       stalls;
  logic         held;
  logic         rst_q;
  mul_operand_t held_data;

  // truncated Booth rows plus compensation, giving product columns N-1 .. 2N-2
  function automatic mul_operand_t ref_product(mul_operand_t x, mul_operand_t y);
    logic [`MUL_WIDTH:0]     yp;
    logic [2*`MUL_WIDTH-1:0] row;
    logic [`ROW_WIDTH-1:0]   acc;
    int                      d;
    int                      nz;
    // y[-1] is zero, so the padded copy starts one column lower
    yp  = {y, 1'b0};
    acc = '0;
    nz  = 0;
    for (int i = 0; i < `BOOTH_DIGITS; i++) begin
      d   = -2 * int'(yp[2*i+2]) + int'(yp[2*i+1]) + int'(yp[2*i]);
      // exact digit * x * 4^i, wrapped to the 2N-bit product width
      row = (2*`MUL_WIDTH)'(longint'(d) * longint'(x) * (longint'(1) << (2*i)));
      if (d != 0) begin
        nz++;
      end
      acc = acc + row[2*`MUL_WIDTH-1:`KEEP_LSB];
    end
    acc = acc + `ROW_WIDTH'((nz + 1) / 2);
    return acc[`MUL_WIDTH:1];
  endfunction

  always @(posedge clk) begin : monitor
    pend_t item;
    if (!rst_n) begin
      held  = 1'b0;
      rst_q = 1'b0;
    end else begin
      cycle++;
      // first edge after release sees the pipe empty and ready
      if (!rst_q && (out_valid !== 1'b0 || in_ready !== 1'b1)) begin
        $display("ERROR at %0t: after reset out_valid=%b in_ready=%b", $time, out_valid, in_ready);
        value_errs++;
      end
      rst_q = 1'b1;
      if (held) begin
        if (out_valid !== 1'b1 || out_data !== held_data) begin
          $display("ERROR at %0t: stalled output moved from %0d to %0d", $time, held_data,
                   out_data);
          value_errs++;
        end
      end else if (out_valid) begin
        if (fifo.size() == 0) begin
          $display("At time %0t a result came out with no input waiting for it", $time);
          proto_errs++;
        end else if (cycle != fifo[0].cyc + 3 + stalls - fifo[0].stl) begin
          // each stall cycle freezes the whole pipe and adds one cycle
          $display("ERROR at %0t: result appeared %0d cycles after its input", $time,
                   cycle - fifo[0].cyc);
          value_errs++;
        end
      end
      if (out_valid && out_ready && fifo.size() != 0) begin
        item = fifo.pop_front();
        compared++;
        if (out_data !== item.want) begin
          $display("ERROR at %0t: x=%0d y=%0d expected %0d got %0d", $time, item.ops.x,
                   item.ops.y, item.want, out_data);
          value_errs++;
        end
      end
      if (in_valid && in_ready) begin
        item.ops  = in_data;
        item.want = ref_product(in_data.x, in_data.y);
        item.cyc  = cycle;
        item.stl  = stalls;
        fifo.push_back(item);
      end
      held      = out_valid && !out_ready;
      held_data = out_data;
      if (held) begin
        stalls++;
      end
      pending = fifo.size();
    end
  end

endmodule

/* testbench/tb_booth_mul.sv */
// testbench top with clock, reset, LFSR stimulus, watchdog,
// the multiplier instance and its stream monitor
`include "booth_defs.svh"

module tb_booth_mul
  import booth_pkg::*;
();

  localparam int     N_CORNER  = 25;
  localparam int     N_STREAM  = 200;
  localparam int     N_STALL   = 300;
  localparam int     MAX_STALL = 4;
  localparam int     N_TXN     = N_CORNER + N_STREAM + N_STALL;
  localparam longint TIMEOUT   = longint'(N_TXN) * (3 + MAX_STALL) * 8 + 2000;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  logic         in_ready;
  mul_in_t      in_data;
  logic         out_valid;
  logic         out_ready;
  mul_operand_t out_data;
  int           value_errs;
  int           proto_errs;
  int           compared;
  int           pending;
  logic [31:0]  lfsr_state;
  logic         stall_mode;
  int           stall_run;
  mul_operand_t corners [5];

  always #4 clk = ~clk;

  booth_mul_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .out_ready (out_ready),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  booth_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .value_errs (value_errs),
    .proto_errs (proto_errs),
    .compared   (compared),
    .pending    (pending)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // gathers n bits, the LFSR moves one step per bit
  task automatic take_bits(input int n, output logic [31:0] r);
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
  endtask

  // a stall never runs longer than MAX_STALL cycles
  task automatic drive_ready();
    logic [31:0] r;
    if (!stall_mode || stall_run >= MAX_STALL) begin
      out_ready = 1'b1;
    end else begin
      take_bits(1, r);
      out_ready = r[0];
    end
    stall_run = out_ready ? 0 : stall_run + 1;
  endtask

  // offers one operand pair and holds it until the pipe takes it
  task automatic send(input mul_operand_t a, input mul_operand_t b);
    logic [31:0] r;
    logic        took;
    if (stall_mode) begin
      take_bits(2, r);
      if (r[1:0] == 2'b00) begin
        in_valid = 1'b0;
        @(negedge clk);
        drive_ready();
      end
    end
    in_valid = 1'b1;
    in_data  = '{x: a, y: b};
    took     = 1'b0;
    while (!took) begin
      @(posedge clk);
      took = in_ready;
      @(negedge clk);
      drive_ready();
    end
    in_valid = 1'b0;
  endtask

  task automatic send_random();
    logic [31:0] ra;
    logic [31:0] rb;
    take_bits(`MUL_WIDTH, ra);
    take_bits(`MUL_WIDTH, rb);
    send(mul_operand_t'(ra[`MUL_WIDTH-1:0]), mul_operand_t'(rb[`MUL_WIDTH-1:0]));
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_data    = '0;
    out_ready  = 1'b1;
    stall_mode = 1'b0;
    stall_run  = 0;
    lfsr_state = 32'hac9d;
    // zero, one, all ones, most positive and most negative
    corners[0] = '0;
    corners[1] = `MUL_WIDTH'(1);
    corners[2] = '1;
    corners[3] = {1'b0, {(`MUL_WIDTH-1){1'b1}}};
    corners[4] = {1'b1, {(`MUL_WIDTH-1){1'b0}}};
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send(corners[i], corners[j]);
      end
    end
    // back to back stream, one result per cycle
    repeat (N_STREAM) send_random();
    stall_mode = 1'b1;
    repeat (N_STALL) send_random();
    stall_mode = 1'b0;
    out_ready  = 1'b1;
    while (pending != 0) @(negedge clk);
    // a few idle cycles to catch any stray output
    repeat (6) @(negedge clk);
    if (compared != N_TXN) begin
      $display("Only %0d of %0d results were compared", compared, N_TXN);
    end
    $display("value errors %0d, protocol errors %0d, compared %0d, still pending %0d",
             value_errs, proto_errs, compared, pending);
    if (value_errs == 0 && proto_errs == 0 && pending == 0 && compared == N_TXN) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("Timeout: the run did not finish within %0d time units", TIMEOUT);
    $display("Test failures found");
    $finish;
  end

endmodule

/* files.f */
+incdir+design
design/booth_pkg.sv
design/booth_encoder.sv
design/pp_compress.sv
design/final_adder.sv
design/booth_mul_top.sv
testbench/booth_checker.sv
testbench/tb_booth_mul.sv

/* Makefile */
# Verilator build and run of the Booth multiplier testbench

VERILATOR ?= verilator
TOP       ?= tb_booth_mul
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failures found
PASS_MSG  ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: no pass line in $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
